// File: rtl/branch_pkg.sv
package branch_pkg;

    localparam int xlen         = 32;
    localparam int rob_tag_len  = 5;
    localparam int flush_cycles = 3;   // Front end refill time
    localparam int result_depth = 2;

    // Branch and jump functions handled by the stage
    typedef enum logic [3:0] {
        btu_beq,
        btu_bne,
        btu_blt,
        btu_bge,
        btu_bltu,
        btu_bgeu,
        btu_jal,
        btu_jalr,
        btu_nop
    } insn_func_e;

    // Entry as issued by the reservation station
    typedef struct packed {
        insn_func_e             func;
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        imm;
        logic [xlen-1:0]        value_src1;
        logic [xlen-1:0]        value_src2;
        logic                   pred_taken;    // Predictor direction
        logic [xlen-1:0]        pred_target;   // Predictor target
        logic [rob_tag_len-1:0] insn_tag;
        logic [rob_tag_len-1:0] tag_dest;
    } rs_entry_t;

    typedef struct packed {
        logic                   taken;
        logic [xlen-1:0]        target_pc;
        logic [xlen-1:0]        wb_data;       // Link value for jumps
        logic [xlen-1:0]        redirect_pc;
        logic                   mispredict;
        logic [rob_tag_len-1:0] insn_tag;
        logic [rob_tag_len-1:0] result_tag;
        logic                   has_dest;
    } br_result_t;

    // Word broadcast on the common data bus
    typedef struct packed {
        logic [rob_tag_len-1:0] tag;
        logic [rob_tag_len-1:0] result_tag;
        logic [xlen-1:0]        value;
        logic                   has_dest;
        logic                   mispredict;
    } cdb_packet_t;

endpackage

// File: rtl/branch_unit.sv
`timescale 1ns/10ps

module branch_unit import branch_pkg::*; (
    input  rs_entry_t  entry,
    output br_result_t result
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] seq_pc;      // Fall-through address
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;
    logic [xlen-1:0] next_pc;
    logic            taken;
    logic            is_jump;
    logic            wrong_dir;
    logic            wrong_target;

    assign pc  = entry.pc;
    assign imm = entry.imm;
    assign rs1 = entry.value_src1;
    assign rs2 = entry.value_src2;

    assign seq_pc  = pc + 32'd4;
    assign is_jump = (entry.func == btu_jal) || (entry.func == btu_jalr);

    // Condition resolution
    always_comb begin
        unique case (entry.func)
            btu_beq:  taken = rs1 == rs2;
            btu_bne:  taken = rs1 != rs2;
            btu_blt:  taken = $signed(rs1) < $signed(rs2);
            btu_bge:  taken = $signed(rs1) >= $signed(rs2);
            btu_bltu: taken = rs1 < rs2;
            btu_bgeu: taken = rs1 >= rs2;
            btu_jal,
            btu_jalr: taken = 1'b1;
            default:  taken = 1'b0;   // nop never branches
        endcase
    end

    // Target and link value
    always_comb begin
        if (entry.func == btu_jalr) begin
            target = (rs1 + imm) & ~32'd1;   // Bit 0 dropped for JALR
        end else begin
            target = pc + imm;
        end
        link = is_jump ? seq_pc : '0;
    end

    assign next_pc = taken ? target : seq_pc;

    // Compare actual outcome against the prediction
    assign wrong_dir    = taken != entry.pred_taken;
    assign wrong_target = taken && (target != entry.pred_target);

    always_comb begin
        result.taken       = taken;
        result.target_pc   = target;
        result.wb_data     = link;
        result.redirect_pc = next_pc;
        result.mispredict  = wrong_dir || wrong_target;
        result.insn_tag    = entry.insn_tag;
        result.result_tag  = entry.tag_dest;
        result.has_dest    = is_jump;   // Only jumps write rd
    end

endmodule

// File: rtl/branch_recover_fsm.sv
`timescale 1ns/10ps

module branch_recover_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic issue_valid,
    input  logic buf_full,
    input  logic mispredict,
    input  logic timer_busy,
    output logic issue_ready,
    output logic accept,
    output logic timer_start
);

    typedef enum logic [1:0] {
        reset_hold,
        run,
        recover
    } state_e;

    state_e state;
    state_e state_next;
    logic   blocked;

    // Issue is held off in the reset cycle and while the front end refills
    always_comb begin
        blocked = 1'b0;
        case (state)
            reset_hold: blocked = 1'b1;
            recover:    blocked = timer_busy;
            default:    blocked = 1'b0;
        endcase
    end

    assign issue_ready = !blocked && !buf_full;
    assign accept      = issue_valid && issue_ready;
    assign timer_start = accept && mispredict;

    always_comb begin
        state_next = state;
        case (state)
            reset_hold: state_next = run;
            run: begin
                if (timer_start) begin
                    state_next = recover;
                end
            end
            recover: begin
                if (timer_start) begin
                    state_next = recover;   // Back-to-back mispredict restarts
                end else if (!timer_busy) begin
                    state_next = run;
                end
            end
            default: state_next = reset_hold;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= reset_hold;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: rtl/recovery_timer.sv
`timescale 1ns/10ps

module recovery_timer import branch_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic busy
);

    localparam int cnt_w = $clog2(flush_cycles + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= cnt_w'(flush_cycles);   // Reload on every flush
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = count != '0;

endmodule

// File: rtl/branch_result_buf.sv
`timescale 1ns/10ps

module branch_result_buf import branch_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  br_result_t      push_result,
    input  logic            cdb_ack,
    output logic            full,
    output logic            cdb_valid,
    output cdb_packet_t     cdb_pkt,
    output logic            flush,
    output logic [xlen-1:0] redirect_pc
);

    localparam int ptr_w = (result_depth > 1) ? $clog2(result_depth) : 1;
    localparam int cnt_w = $clog2(result_depth + 1);

    cdb_packet_t      entries [result_depth];
    cdb_packet_t      push_pkt;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             pop;

    // Result to CDB word
    always_comb begin
        push_pkt.tag        = push_result.insn_tag;
        push_pkt.result_tag = push_result.result_tag;
        push_pkt.value      = push_result.wb_data;
        push_pkt.has_dest   = push_result.has_dest;
        push_pkt.mispredict = push_result.mispredict;
    end

    assign cdb_valid = count != '0;
    assign cdb_pkt   = entries[rd_ptr];
    assign pop       = cdb_valid && cdb_ack;
    assign full      = (count == cnt_w'(result_depth)) && !pop;   // A slot frees on ack

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(result_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(result_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_pkt;
        end
    end

    // Redirect lasts one cycle after a mispredicting push
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush <= 1'b0;
        end else begin
            flush <= push && push_result.mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (push && push_result.mispredict) begin
            redirect_pc <= push_result.redirect_pc;
        end
    end

endmodule

// File: rtl/branch_stage_top.sv
`timescale 1ns/10ps

module branch_stage_top import branch_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue_valid,
    input  rs_entry_t       issue_entry,
    output logic            issue_ready,
    output logic            cdb_valid,
    output cdb_packet_t     cdb_pkt,
    input  logic            cdb_ack,
    output logic            flush,
    output logic [xlen-1:0] redirect_pc
);

    br_result_t resolved;
    logic       accept;
    logic       buf_full;
    logic       timer_start;
    logic       timer_busy;

    branch_unit u_branch_unit (
        .entry  (issue_entry),
        .result (resolved)
    );

    branch_recover_fsm u_recover_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .buf_full    (buf_full),
        .mispredict  (resolved.mispredict),
        .timer_busy  (timer_busy),
        .issue_ready (issue_ready),
        .accept      (accept),
        .timer_start (timer_start)
    );

    recovery_timer u_recovery_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .busy  (timer_busy)
    );

    // Results queue here until the CDB takes them
    branch_result_buf u_result_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (accept),
        .push_result (resolved),
        .cdb_ack     (cdb_ack),
        .full        (buf_full),
        .cdb_valid   (cdb_valid),
        .cdb_pkt     (cdb_pkt),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: tests/branch_stage_tb.sv
`timescale 1ns/10ps

module branch_stage_tb import branch_pkg::*; ();

    localparam int n_cond   = 18;
    localparam int n_jump   = 4;
    localparam int n_mis    = 3;
    localparam int n_bp     = 4;
    localparam int n_random = 40;
    localparam int n_total  = n_cond + n_jump + n_mis + n_bp + n_random;
    localparam int period   = 100;

    logic            clk;
    logic            rst_n;
    logic            issue_valid;
    rs_entry_t       issue_entry;
    logic            issue_ready;
    logic            cdb_valid;
    cdb_packet_t     cdb_pkt;
    logic            cdb_ack;
    logic            flush;
    logic [xlen-1:0] redirect_pc;

    cdb_packet_t     exp_q[$];         // Results the buffer should hold, oldest first
    cdb_packet_t     exp_pkt;
    br_result_t      ref_r;
    logic            exp_ready;
    logic            exp_flush;
    logic [xlen-1:0] exp_redirect;
    int              rec_left;         // Cycles of blocked issue still expected
    logic            ack_level;
    logic            ack_random;
    logic            ack_next;
    int              errors;
    int              checks;
    int              tests_run;
    int              issued;
    int              acked;
    int              next_tag;

    // Edge operands for the compare tests
    logic [xlen-1:0] op_a [3] = '{32'h0000_1234, 32'h8000_0000, 32'hffff_ffff};
    logic [xlen-1:0] op_b [3] = '{32'h0000_1234, 32'h0000_0001, 32'h0000_0000};

    branch_stage_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb_pkt     (cdb_pkt),
        .cdb_ack     (cdb_ack),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    always #(period / 2) clk = ~clk;

    // Expected resolution of one entry
    function automatic br_result_t ref_resolve(input rs_entry_t e);
        br_result_t r;
        logic       jump;
        r    = '0;
        jump = (e.func == btu_jal) || (e.func == btu_jalr);
        case (e.func)
            btu_beq:  r.taken = e.value_src1 == e.value_src2;
            btu_bne:  r.taken = e.value_src1 != e.value_src2;
            btu_blt:  r.taken = $signed(e.value_src1) < $signed(e.value_src2);
            btu_bge:  r.taken = $signed(e.value_src1) >= $signed(e.value_src2);
            btu_bltu: r.taken = e.value_src1 < e.value_src2;
            btu_bgeu: r.taken = e.value_src1 >= e.value_src2;
            btu_jal:  r.taken = 1'b1;
            btu_jalr: r.taken = 1'b1;
            default:  r.taken = 1'b0;
        endcase
        if (e.func == btu_jalr) begin
            r.target_pc = e.value_src1 + e.imm;
            r.target_pc[0] = 1'b0;
        end else begin
            r.target_pc = e.pc + e.imm;
        end
        r.wb_data     = jump ? e.pc + 32'd4 : 32'd0;
        r.redirect_pc = r.taken ? r.target_pc : e.pc + 32'd4;
        r.mispredict  = (r.taken != e.pred_taken) ||
                        (r.taken && (r.target_pc != e.pred_target));
        r.insn_tag    = e.insn_tag;
        r.result_tag  = e.tag_dest;
        r.has_dest    = jump;
        return r;
    endfunction

    // Builds an entry whose prediction is correct
    function automatic rs_entry_t make_entry(input insn_func_e func,
                                             input logic [xlen-1:0] pc, imm, s1, s2);
        rs_entry_t  e;
        br_result_t r;
        e            = '0;
        e.func       = func;
        e.pc         = pc;
        e.imm        = imm;
        e.value_src1 = s1;
        e.value_src2 = s2;
        e.tag_dest   = 5'(pc >> 2);
        r            = ref_resolve(e);
        e.pred_taken  = r.taken;
        e.pred_target = r.target_pc;
        return e;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic compare_cdb(input cdb_packet_t got, input cdb_packet_t want);
        checks++;
        if (got !== want) begin
            report_error($sformatf("cdb_pkt %h, expected %h", got, want));
        end
    endtask

    task automatic compare_redirect(input logic got_flush, input logic [xlen-1:0] got_pc,
                                    input logic want_flush, input logic [xlen-1:0] want_pc);
        checks++;
        if (got_flush !== want_flush) begin
            report_error($sformatf("flush %b, expected %b", got_flush, want_flush));
        end else if (want_flush && (got_pc !== want_pc)) begin
            report_error($sformatf("redirect_pc %h, expected %h", got_pc, want_pc));
        end
    endtask

    task automatic compare_ready(input logic got, input logic want);
        checks++;
        if (got !== want) begin
            report_error($sformatf("issue_ready %b, expected %b", got, want));
        end
    endtask

    // Offers one entry and holds it until the handshake
    task automatic issue_one(input rs_entry_t e);
        bit done;
        e.insn_tag  = 5'(next_tag);
        next_tag++;
        issue_valid = 1'b1;
        issue_entry = e;
        done        = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = issue_ready;
            @(posedge clk);
            #10;
        end
        issue_valid = 1'b0;
        issued++;
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
        end while ((exp_q.size() != 0) || (rec_left != 0));
        #10;
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    always @(posedge clk) begin
        ack_next = ack_random ? 1'($urandom_range(1, 0)) : ack_level;
        #10;
        cdb_ack = ack_next;
    end

    // Compares DUT outputs against the model in the middle of each cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            rec_left  = 1;             // reset_hold cycle
            exp_flush = 1'b0;
        end else begin
            exp_ready = (rec_left == 0) && !((exp_q.size() >= result_depth) && !cdb_ack);
            compare_ready(issue_ready, exp_ready);
            if (exp_q.size() != 0) begin
                if (!cdb_valid) begin
                    report_error("cdb_valid low while results are pending");
                end else begin
                    compare_cdb(cdb_pkt, exp_q[0]);
                end
                if (cdb_ack) begin
                    void'(exp_q.pop_front());
                end
            end else if (cdb_valid) begin
                report_error("cdb_valid high with no result pending");
            end
            if (cdb_valid && cdb_ack) begin
                acked++;                   // Packet taken by the CDB
            end
            compare_redirect(flush, redirect_pc, exp_flush, exp_redirect);
            exp_flush = 1'b0;
            if (issue_valid && issue_ready) begin
                ref_r              = ref_resolve(issue_entry);
                exp_pkt.tag        = ref_r.insn_tag;
                exp_pkt.result_tag = ref_r.result_tag;
                exp_pkt.value      = ref_r.wb_data;
                exp_pkt.has_dest   = ref_r.has_dest;
                exp_pkt.mispredict = ref_r.mispredict;
                exp_q.push_back(exp_pkt);
                if (ref_r.mispredict) begin
                    exp_flush    = 1'b1;
                    exp_redirect = ref_r.redirect_pc;
                    rec_left     = flush_cycles;
                end
            end else if (rec_left > 0) begin
                rec_left--;
            end
        end
    end

    initial begin
        #(200 * n_total * period + 20 * period);
        $display("Watchdog timeout: issued entries were not all acknowledged in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        rs_entry_t       e;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] s1;
        logic [xlen-1:0] s2;
        int              err_start;
        void'($urandom(32'hb763));
        clk = 1'b0;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_entry = '0;
        cdb_ack = 1'b0;
        ack_level = 1'b1;
        ack_random = 1'b0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        issued = 0;
        acked = 0;
        next_tag = 0;
        exp_redirect = '0;
        repeat (16) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // Wrong direction on every branch so that each redirect_pc is visible
        err_start = errors;
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                e = make_entry(insn_func_e'(f), 32'h100 + 32'(f * 48 + p * 16),
                               (p == 1) ? 32'hffff_ffc0 : 32'h80, op_a[p], op_b[p]);
                e.pred_taken = !e.pred_taken;
                issue_one(e);
            end
        end
        wait_drain();
        report_test("conditional branches", err_start);

        err_start = errors;
        issue_one(make_entry(btu_jal, 32'h1000, 32'h40, 32'h0, 32'h0));
        e = make_entry(btu_jalr, 32'h1100, 32'h10, 32'h2001, 32'h0);
        e.pred_target = 32'h2011;      // Bit 0 left set
        issue_one(e);
        issue_one(make_entry(btu_jalr, 32'h1200, 32'h7, 32'h3000, 32'h0));
        e = make_entry(btu_jal, 32'h1300, 32'hffff_ff00, 32'h0, 32'h0);
        e.pred_taken = 1'b0;
        issue_one(e);
        wait_drain();
        report_test("jumps", err_start);

        err_start = errors;
        e = make_entry(btu_beq, 32'h2000, 32'h20, 32'h55, 32'h55);
        e.pred_taken = 1'b0;
        issue_one(e);
        e = make_entry(btu_bne, 32'h2100, 32'h30, 32'h1, 32'h2);
        e.pred_target = 32'h2200;
        issue_one(e);
        issue_one(make_entry(btu_blt, 32'h2200, 32'h40, 32'hffff_fff0, 32'h3));
        wait_drain();
        report_test("misprediction", err_start);

        // Third entry must stall until the CDB takes a packet
        err_start = errors;
        ack_level = 1'b0;
        issue_one(make_entry(btu_bltu, 32'h3000, 32'h8, 32'h1, 32'h9));
        issue_one(make_entry(btu_jal, 32'h3100, 32'h8, 32'h0, 32'h0));
        fork
            issue_one(make_entry(btu_bge, 32'h3200, 32'h8, 32'h4, 32'h4));
            begin
                repeat (5) @(posedge clk);
                #10;
                ack_level = 1'b1;
            end
        join
        issue_one(make_entry(btu_nop, 32'h3300, 32'h8, 32'h0, 32'h0));
        wait_drain();
        report_test("back-pressure and order", err_start);

        err_start = errors;
        ack_random = 1'b1;
        for (int i = 0; i < n_random; i++) begin
            pc = $urandom & 32'hffff_fffc;
            s1 = $urandom;
            s2 = ($urandom_range(3, 0) == 0) ? s1 : $urandom;
            e  = make_entry(insn_func_e'($urandom_range(8, 0)), pc, $urandom, s1, s2);
            if ($urandom_range(1, 0) == 1) begin
                e.pred_taken = !e.pred_taken;
            end
            if ($urandom_range(3, 0) == 0) begin
                e.pred_target = e.pred_target ^ 32'h10;
            end
            issue_one(e);
        end
        wait_drain();
        ack_random = 1'b0;
        report_test("random stream", err_start);

        repeat (4) @(posedge clk);
        if (acked != issued) begin
            errors++;
            $display("Lost packets: %0d entries issued but %0d acknowledged", issued, acked);
        end
        $display("Done: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/branch_pkg.sv
rtl/branch_unit.sv
rtl/branch_recover_fsm.sv
rtl/recovery_timer.sv
rtl/branch_result_buf.sv
rtl/branch_stage_top.sv
tests/branch_stage_tb.sv
